//--- hmac.f
+incdir+include
hw/hmac_pkg.sv
hw/sha512_engine.sv
hw/hmac_ctrl.sv
hw/hmac_axil_regs.sv
hw/hmac.sv
tb/tb_hmac.sv

//--- hw/hmac.sv
// HMAC-SHA-512/384 accelerator top
// AXI4-Lite register file, HMAC sequencer and SHA-512 engine

`timescale 1ns/1ns
`default_nettype none

module hmac import hmac_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  addr_t      s_awaddr,
  input  logic       s_awvalid,
  output logic       s_awready,
  input  word_t      s_wdata,
  input  logic       s_wvalid,
  output logic       s_wready,
  output logic [1:0] s_bresp,
  output logic       s_bvalid,
  input  logic       s_bready,
  input  addr_t      s_araddr,
  input  logic       s_arvalid,
  output logic       s_arready,
  output word_t      s_rdata,
  output logic [1:0] s_rresp,
  output logic       s_rvalid,
  input  logic       s_rready,
  output logic       error_intr,
  output logic       notif_intr,
  output logic       busy
);

  logic    init_cmd;
  logic    next_cmd;
  logic    zeroize;
  logic    mode;
  key_t    key;
  block_t  block;
  logic    ready;
  logic    tag_valid;
  digest_t tag;
  logic    key_zero_error;
  logic    tag_done;
  logic    eng_start;
  block_t  eng_block;
  digest_t eng_chain;
  logic    eng_done;
  digest_t eng_digest;

  assign busy = ~ready;

  hmac_axil_regs u_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .s_awaddr       (s_awaddr),
    .s_awvalid      (s_awvalid),
    .s_awready      (s_awready),
    .s_wdata        (s_wdata),
    .s_wvalid       (s_wvalid),
    .s_wready       (s_wready),
    .s_bresp        (s_bresp),
    .s_bvalid       (s_bvalid),
    .s_bready       (s_bready),
    .s_araddr       (s_araddr),
    .s_arvalid      (s_arvalid),
    .s_arready      (s_arready),
    .s_rdata        (s_rdata),
    .s_rresp        (s_rresp),
    .s_rvalid       (s_rvalid),
    .s_rready       (s_rready),
    .ready          (ready),
    .tag_valid      (tag_valid),
    .tag            (tag),
    .key_zero_error (key_zero_error),
    .tag_done       (tag_done),
    .init_cmd       (init_cmd),
    .next_cmd       (next_cmd),
    .zeroize        (zeroize),
    .mode           (mode),
    .key            (key),
    .block          (block),
    .error_intr     (error_intr),
    .notif_intr     (notif_intr)
  );

  hmac_ctrl u_ctrl (
    .clk            (clk),
    .reset_n        (reset_n),
    .init_cmd       (init_cmd),
    .next_cmd       (next_cmd),
    .zeroize        (zeroize),
    .mode           (mode),
    .key            (key),
    .block          (block),
    .eng_done       (eng_done),
    .eng_digest     (eng_digest),
    .ready          (ready),
    .tag_valid      (tag_valid),
    .tag            (tag),
    .key_zero_error (key_zero_error),
    .tag_done       (tag_done),
    .eng_start      (eng_start),
    .eng_block      (eng_block),
    .eng_chain      (eng_chain)
  );

  sha512_engine u_engine (
    .clk      (clk),
    .reset_n  (reset_n),
    .start    (eng_start),
    .block_in (eng_block),
    .chain_in (eng_chain),
    .done     (eng_done),
    .digest   (eng_digest)
  );

endmodule

`default_nettype wire

//--- hw/hmac_axil_regs.sv
// HMAC register file behind an AXI4-Lite slave
// holds key, block, mode and interrupt status, serves status and tag reads

`timescale 1ns/1ns
`default_nettype none

module hmac_axil_regs import hmac_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  addr_t      s_awaddr,
  input  logic       s_awvalid,
  output logic       s_awready,
  input  word_t      s_wdata,
  input  logic       s_wvalid,
  output logic       s_wready,
  output logic [1:0] s_bresp,
  output logic       s_bvalid,
  input  logic       s_bready,
  input  addr_t      s_araddr,
  input  logic       s_arvalid,
  output logic       s_arready,
  output word_t      s_rdata,
  output logic [1:0] s_rresp,
  output logic       s_rvalid,
  input  logic       s_rready,
  input  logic       ready,
  input  logic       tag_valid,
  input  digest_t    tag,
  input  logic       key_zero_error,
  input  logic       tag_done,
  output logic       init_cmd,
  output logic       next_cmd,
  output logic       zeroize,
  output logic       mode,
  output key_t       key,
  output block_t     block,
  output logic       error_intr,
  output logic       notif_intr
);

  logic  wr_en;
  logic  rd_en;
  logic  wr_ctrl;
  logic  wr_intr;
  logic  wr_key;
  logic  wr_blk;
  logic  err_sts;
  logic  done_sts;
  word_t rd_data;

  // --------------------
  // handshake
  // --------------------
  // address and data are taken together, one write in flight
  assign wr_en     = s_awvalid && s_wvalid && !s_bvalid;
  assign s_awready = wr_en;
  assign s_wready  = wr_en;
  assign s_bresp   = RESP_OKAY;

  assign rd_en     = s_arvalid && !s_rvalid;
  assign s_arready = !s_rvalid;
  assign s_rresp   = RESP_OKAY;

  // byte lanes ignored, dword aligned decode
  assign wr_ctrl = wr_en && (s_awaddr[11:2] == CTRL_ADDR[11:2]);
  assign wr_intr = wr_en && (s_awaddr[11:2] == INTR_ADDR[11:2]);
  assign wr_key  = wr_en && (s_awaddr[11:6] == KEY_BASE[11:6]);
  assign wr_blk  = wr_en && (s_awaddr[11:7] == BLOCK_BASE[11:7]);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      s_bvalid <= 1'b0;
      s_rvalid <= 1'b0;
      s_rdata  <= '0;
    end else begin
      if (wr_en) begin
        s_bvalid <= 1'b1;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
      if (rd_en) begin
        s_rvalid <= 1'b1;
        s_rdata  <= rd_data;
      end else if (s_rready) begin
        s_rvalid <= 1'b0;
      end
    end
  end

  // --------------------
  // control and storage
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_cmd <= 1'b0;
      next_cmd <= 1'b0;
      zeroize  <= 1'b0;
      mode     <= 1'b0;
      err_sts  <= 1'b0;
      done_sts <= 1'b0;
      key      <= '0;
      block    <= '0;
    end else begin
      // commands only land while the core is idle
      init_cmd <= wr_ctrl && ready && s_wdata[0];
      next_cmd <= wr_ctrl && ready && s_wdata[1];
      zeroize  <= wr_ctrl && s_wdata[3];

      // set wins over write-1-to-clear
      err_sts  <= key_zero_error || (err_sts && !(wr_intr && s_wdata[0]));
      done_sts <= tag_done || (done_sts && !(wr_intr && s_wdata[1]));

      if (zeroize) begin
        mode  <= 1'b0;
        key   <= '0;
        block <= '0;
      end else if (ready) begin
        if (wr_ctrl) begin
          mode <= s_wdata[2];
        end
        if (wr_key) begin
          key[(KEY_DWORDS - 1 - int'(s_awaddr[5:2])) * 32 +: 32] <= s_wdata;
        end
        if (wr_blk) begin
          block[(BLOCK_DWORDS - 1 - int'(s_awaddr[6:2])) * 32 +: 32] <= s_wdata;
        end
      end
    end
  end

  assign error_intr = err_sts;
  assign notif_intr = done_sts;

  // read mux, dword 0 is the most significant word
  always_comb begin
    rd_data = '0;
    if (s_araddr[11:2] == STATUS_ADDR[11:2]) begin
      rd_data = {30'd0, tag_valid, ready};
    end else if (s_araddr[11:2] == INTR_ADDR[11:2]) begin
      rd_data = {30'd0, done_sts, err_sts};
    end else if (s_araddr[11:6] == KEY_BASE[11:6]) begin
      rd_data = key[(KEY_DWORDS - 1 - int'(s_araddr[5:2])) * 32 +: 32];
    end else if (s_araddr[11:7] == BLOCK_BASE[11:7]) begin
      rd_data = block[(BLOCK_DWORDS - 1 - int'(s_araddr[6:2])) * 32 +: 32];
    end else if (s_araddr[11:6] == TAG_BASE[11:6]) begin
      rd_data = tag[(TAG_DWORDS - 1 - int'(s_araddr[5:2])) * 32 +: 32];
    end
  end

  // responses hold until the manager takes them
  assert property (@(posedge clk) disable iff (!reset_n) s_bvalid && !s_bready |=> s_bvalid)
    else $error("bvalid dropped before bready");
  assert property (@(posedge clk) disable iff (!reset_n) s_rvalid && !s_rready |=> s_rvalid)
    else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

//--- hw/hmac_ctrl.sv
// HMAC sequencer
// runs ipad key, message, opad key and inner digest through the engine, holds the tag

`timescale 1ns/1ns
`default_nettype none

module hmac_ctrl import hmac_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    init_cmd,
  input  logic    next_cmd,
  input  logic    zeroize,
  input  logic    mode,
  input  key_t    key,
  input  block_t  block,
  input  logic    eng_done,
  input  digest_t eng_digest,
  output logic    ready,
  output logic    tag_valid,
  output digest_t tag,
  output logic    key_zero_error,
  output logic    tag_done,
  output logic    eng_start,
  output block_t  eng_block,
  output digest_t eng_chain
);

  hmac_state_e state;
  digest_t     inner_chain;
  digest_t     outer_chain;
  digest_t     iv;
  logic        eng_pending;
  logic        cmd;
  block_t      ipad_block;
  block_t      opad_block;
  block_t      final_block;

  // a zeroized run may leave the engine busy for a while
  assign ready = (state == idle) && !eng_pending;
  assign cmd   = (init_cmd || next_cmd) && ready;
  assign iv    = mode ? SHA512_IV : SHA384_IV;

  // key is zero filled to a full block before the pad
  assign ipad_block = {key, 512'd0} ^ {128{IPAD_BYTE}};
  assign opad_block = {key, 512'd0} ^ {128{OPAD_BYTE}};

  // outer message is 128 pad bytes plus the inner digest
  assign final_block = mode ? {inner_chain, 8'h80, 376'd0, 128'd1536}
                            : {inner_chain[511 -: TAG384_DWORDS * 32], 8'h80, 504'd0,
                               128'd1408};

  always_comb begin
    eng_block = block;
    eng_chain = inner_chain;
    case (state)
      inner_key: begin
        eng_block = ipad_block;
        eng_chain = iv;
      end
      outer_key: begin
        eng_block = opad_block;
        eng_chain = iv;
      end
      outer_final: begin
        eng_block = final_block;
        eng_chain = outer_chain;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state          <= idle;
      eng_start      <= 1'b0;
      eng_pending    <= 1'b0;
      key_zero_error <= 1'b0;
      tag_done       <= 1'b0;
      tag_valid      <= 1'b0;
      tag            <= '0;
      inner_chain    <= '0;
      outer_chain    <= '0;
    end else begin
      eng_start      <= 1'b0;
      key_zero_error <= 1'b0;
      tag_done       <= 1'b0;
      if (eng_start) begin
        eng_pending <= 1'b1;
      end else if (eng_done) begin
        eng_pending <= 1'b0;
      end

      if (zeroize) begin
        state       <= idle;
        eng_start   <= 1'b0;
        tag_valid   <= 1'b0;
        tag         <= '0;
        inner_chain <= '0;
        outer_chain <= '0;
      end else begin
        case (state)
          idle: begin
            if (cmd && key == '0) begin
              key_zero_error <= 1'b1;
            end else if (cmd) begin
              // next skips the ipad block and resumes the inner hash
              state     <= init_cmd ? inner_key : message;
              eng_start <= 1'b1;
              tag_valid <= 1'b0;
            end
          end
          inner_key, message: begin
            if (eng_done) begin
              inner_chain <= eng_digest;
              state       <= (state == inner_key) ? message : outer_key;
              eng_start   <= 1'b1;
            end
          end
          outer_key: begin
            if (eng_done) begin
              outer_chain <= eng_digest;
              state       <= outer_final;
              eng_start   <= 1'b1;
            end
          end
          default: begin
            if (eng_done) begin
              tag       <= mode ? eng_digest
                                : {eng_digest[511 -: TAG384_DWORDS * 32], 128'd0};
              tag_valid <= 1'b1;
              tag_done  <= 1'b1;
              state     <= idle;
            end
          end
        endcase
      end
    end
  end

  // a start only goes out while no block is in flight
  assert property (@(posedge clk) disable iff (!reset_n) eng_start |-> !eng_pending)
    else $error("eng_start while a block is in flight");

endmodule

`default_nettype wire

//--- hw/hmac_pkg.sv
// HMAC-SHA-512/384 shared definitions
// widths, register map, pad bytes, round constants and initial values

`default_nettype none

package hmac_pkg;

  // --------------------
  // widths and types
  // --------------------
  typedef logic [31:0]   word_t;
  typedef logic [11:0]   addr_t;
  typedef logic [511:0]  key_t;
  typedef logic [1023:0] block_t;
  typedef logic [511:0]  digest_t;

  localparam int KEY_DWORDS    = 16;
  localparam int BLOCK_DWORDS  = 32;
  localparam int TAG_DWORDS    = 16;
  localparam int TAG384_DWORDS = 12;
  localparam int NUM_ROUNDS    = 80;

  // --------------------
  // register map
  // --------------------
  localparam addr_t CTRL_ADDR   = 12'h010;
  localparam addr_t STATUS_ADDR = 12'h018;
  localparam addr_t INTR_ADDR   = 12'h01C;
  localparam addr_t KEY_BASE    = 12'h040;
  localparam addr_t BLOCK_BASE  = 12'h080;
  localparam addr_t TAG_BASE    = 12'h100;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // hmac pad bytes
  localparam logic [7:0] IPAD_BYTE = 8'h36;
  localparam logic [7:0] OPAD_BYTE = 8'h5c;

  // --------------------
  // sha-512 constants
  // --------------------
  localparam logic [0:NUM_ROUNDS-1][63:0] SHA512_K = {
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // word a sits in the top 64 bits
  localparam digest_t SHA512_IV = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  localparam digest_t SHA384_IV = {
    64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507, 64'h9159015a3070dd17, 64'h152fecd8f70e5939,
    64'h67332667ffc00b31, 64'h8eb44a8768581511, 64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4
  };

  // sequencer states, one per compression
  typedef enum logic [2:0] {
    idle,
    inner_key,
    message,
    outer_key,
    outer_final
  } hmac_state_e;

endpackage

`default_nettype wire

//--- hw/sha512_engine.sv
// SHA-512 compression of one 1024-bit block
// one load cycle, 80 rounds at one per cycle, then the chaining add

`timescale 1ns/1ns
`default_nettype none

module sha512_engine import hmac_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    start,
  input  block_t  block_in,
  input  digest_t chain_in,
  output logic    done,
  output digest_t digest
);

  logic         busy;
  logic [6:0]   round;
  logic [63:0]  a, b, c, d, e, f, g, h;
  logic [63:0]  w [16];
  digest_t      chain;
  logic [511:0] work;
  logic [63:0]  k_t;
  logic [63:0]  t1;
  logic [63:0]  t2;
  logic [63:0]  w_next;

  function automatic logic [63:0] rotr(input logic [63:0] x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  // --------------------
  // round logic
  // --------------------
  assign work = {a, b, c, d, e, f, g, h};
  assign k_t  = (round < NUM_ROUNDS) ? SHA512_K[round] : '0;

  assign t1 = h + (rotr(e, 14) ^ rotr(e, 18) ^ rotr(e, 41)) + ((e & f) ^ (~e & g))
            + k_t + w[0];
  assign t2 = (rotr(a, 28) ^ rotr(a, 34) ^ rotr(a, 39)) + ((a & b) ^ (a & c) ^ (b & c));

  // schedule word sixteen places ahead of w[0]
  assign w_next = (rotr(w[14], 19) ^ rotr(w[14], 61) ^ (w[14] >> 6)) + w[9]
                + (rotr(w[1], 1) ^ rotr(w[1], 8) ^ (w[1] >> 7)) + w[0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy  <= 1'b0;
      round <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        round <= '0;
      end else if (busy) begin
        if (round == NUM_ROUNDS) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          round <= round + 7'd1;
        end
      end
    end
  end

  // working state and window
  always_ff @(posedge clk) begin
    if (start) begin
      {a, b, c, d, e, f, g, h} <= chain_in;
      chain <= chain_in;
      for (int i = 0; i < 16; i++) begin
        w[i] <= block_in[(15 - i) * 64 +: 64];
      end
    end else if (busy && round < NUM_ROUNDS) begin
      h <= g;
      g <= f;
      f <= e;
      e <= d + t1;
      d <= c;
      c <= b;
      b <= a;
      a <= t1 + t2;
      for (int i = 0; i < 15; i++) begin
        w[i] <= w[i + 1];
      end
      w[15] <= w_next;
    end else if (busy) begin
      // final add, word by word mod 2^64
      for (int i = 0; i < 8; i++) begin
        digest[i * 64 +: 64] <= chain[i * 64 +: 64] + work[i * 64 +: 64];
      end
    end
  end

  // caller must wait for done before the next block
  assert property (@(posedge clk) disable iff (!reset_n) busy |-> !start)
    else $error("start while a block is in progress");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile the HMAC testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_hmac -f hmac.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_hmac)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

//--- include/hmac_tb_axil.svh
// AXI4-Lite manager tasks and RFC 4231 test case 2 vectors
// included inside the testbench module

`ifndef HMAC_TB_AXIL_SVH
`define HMAC_TB_AXIL_SVH

localparam int BUS_LIMIT  = 100;
localparam int MSG_BYTES  = 28;
localparam int MSG_DWORDS = 7;

// key "Jefe", zero filled
localparam word_t KEY_JEFE = 32'h4a656665;
// "what do ya want for nothing?"
localparam logic [223:0] MSG_TC2 =
  224'h7768617420646f2079612077616e7420666f72206e6f7468696e673f;

localparam logic [511:0] RFC_TAG512 = {
  128'h164b7a7bfcf819e2e395fbe73b56e0a3, 128'h87bd64222e831fd610270cd7ea250554,
  128'h9758bf75c05a994a6d034f65f8f0e6fd, 128'hcaeab1a34d4a6b4b636e070a38bce737
};
localparam logic [383:0] RFC_TAG384 = {
  128'haf45d2e376484031617f78d2b58a6b1b, 128'h9c7ef464f5a01b47e42ec3736322445e,
  128'h8e2240ca5e69e2c78b3239ecfab21649
};

// random delay before taking a response
task automatic response_gap();
  int gap;
  gap = int'($urandom % 32'd4);
  repeat (gap) begin
    @(posedge clk);
    #1;
  end
endtask

task automatic write_reg(input addr_t addr, input word_t data);
  int cycles;
  s_awaddr  = addr;
  s_wdata   = data;
  s_awvalid = 1'b1;
  s_wvalid  = 1'b1;
  cycles    = 0;
  #1;
  // ready follows valid combinationally
  while (!(s_awready && s_wready)) begin
    if (cycles == BUS_LIMIT) abort_run("timeout waiting for awready and wready");
    cycles++;
    @(posedge clk);
    #2;
  end
  @(posedge clk);
  #1;
  s_awvalid = 1'b0;
  s_wvalid  = 1'b0;
  response_gap();
  s_bready = 1'b1;
  cycles   = 0;
  while (!s_bvalid) begin
    if (cycles == BUS_LIMIT) abort_run("timeout waiting for bvalid");
    cycles++;
    @(posedge clk);
    #1;
  end
  @(posedge clk);
  #1;
  s_bready = 1'b0;
endtask

task automatic read_reg(input addr_t addr, output word_t data);
  int cycles;
  s_araddr  = addr;
  s_arvalid = 1'b1;
  cycles    = 0;
  #1;
  while (!s_arready) begin
    if (cycles == BUS_LIMIT) abort_run("timeout waiting for arready");
    cycles++;
    @(posedge clk);
    #2;
  end
  @(posedge clk);
  #1;
  s_arvalid = 1'b0;
  response_gap();
  s_rready = 1'b1;
  cycles   = 0;
  while (!s_rvalid) begin
    if (cycles == BUS_LIMIT) abort_run("timeout waiting for rvalid");
    cycles++;
    @(posedge clk);
    #1;
  end
  data = s_rdata;
  @(posedge clk);
  #1;
  s_rready = 1'b0;
endtask

`endif

//--- tb/tb_hmac.sv
// testbench for the HMAC-SHA-512/384 accelerator
// runs RFC 4231 case 2 in both modes, the zero key, zeroize and busy writes

`timescale 1ns/1ns
`default_nettype none

module tb_hmac import hmac_pkg::*; ();

  logic       clk;
  logic       reset_n;
  addr_t      s_awaddr;
  logic       s_awvalid;
  logic       s_awready;
  word_t      s_wdata;
  logic       s_wvalid;
  logic       s_wready;
  logic [1:0] s_bresp;
  logic       s_bvalid;
  logic       s_bready;
  addr_t      s_araddr;
  logic       s_arvalid;
  logic       s_arready;
  word_t      s_rdata;
  logic [1:0] s_rresp;
  logic       s_rvalid;
  logic       s_rready;
  logic       error_intr;
  logic       notif_intr;
  logic       busy;

  int errors;
  int checks;
  int tests;
  int test_base;

  localparam int OP_LIMIT = 2000;

  `include "hmac_tb_axil.svh"

  always #10 clk = ~clk;

  hmac u_hmac (
    .clk        (clk),
    .reset_n    (reset_n),
    .s_awaddr   (s_awaddr),
    .s_awvalid  (s_awvalid),
    .s_awready  (s_awready),
    .s_wdata    (s_wdata),
    .s_wvalid   (s_wvalid),
    .s_wready   (s_wready),
    .s_bresp    (s_bresp),
    .s_bvalid   (s_bvalid),
    .s_bready   (s_bready),
    .s_araddr   (s_araddr),
    .s_arvalid  (s_arvalid),
    .s_arready  (s_arready),
    .s_rdata    (s_rdata),
    .s_rresp    (s_rresp),
    .s_rvalid   (s_rvalid),
    .s_rready   (s_rready),
    .error_intr (error_intr),
    .notif_intr (notif_intr),
    .busy       (busy)
  );

  // --------------------
  // bus and interrupt rules
  // --------------------
  assert property (@(posedge clk) disable iff (!reset_n) s_bvalid |-> s_bresp == 2'b00)
    else begin
      errors++;
      $display("CHECK FAILED at %0t ns: s_bresp expected 0, got %0d", $time, s_bresp);
    end
  assert property (@(posedge clk) disable iff (!reset_n) s_rvalid |-> s_rresp == 2'b00)
    else begin
      errors++;
      $display("CHECK FAILED at %0t ns: s_rresp expected 0, got %0d", $time, s_rresp);
    end
  // interrupts only rise once the core is idle again
  assert property (@(posedge clk) disable iff (!reset_n) $rose(notif_intr) |-> !busy)
    else begin
      errors++;
      $display("CHECK FAILED at %0t ns: busy expected 0, got %0d", $time, busy);
    end
  assert property (@(posedge clk) disable iff (!reset_n) $rose(error_intr) |-> !busy)
    else begin
      errors++;
      $display("CHECK FAILED at %0t ns: busy expected 0, got %0d", $time, busy);
    end

  task automatic abort_run(input string reason);
    $display("%s at %0t ns", reason, $time);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + 1);
    $display("Verification failed");
    $finish;
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    assert (actual == expected)
      else begin
        errors++;
        $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                 $time, name, expected, actual);
      end
  endtask

  task automatic expect_reg(input string name, input addr_t addr, input word_t expected);
    word_t value;
    read_reg(addr, value);
    check_word(name, expected, value);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_base) ? "pass" : "fail");
    test_base = errors;
  endtask

  function automatic logic flag_level(input string name);
    if (name == "notif_intr") return notif_intr;
    if (name == "error_intr") return error_intr;
    return busy;
  endfunction

  task automatic wait_for_flag(input string name);
    int cycles;
    cycles = 0;
    while (flag_level(name) !== 1'b1) begin
      if (cycles == OP_LIMIT) abort_run({"timeout waiting for ", name});
      cycles++;
      @(posedge clk);
      #1;
    end
  endtask

  // message, 0x80, zeros, then the bit length of ipad block plus data
  function automatic word_t padded_msg_word(input int i);
    if (i < MSG_DWORDS) return MSG_TC2[MSG_DWORDS * 32 - 1 - 32 * i -: 32];
    if (i == MSG_DWORDS) return 32'h8000_0000;
    if (i == BLOCK_DWORDS - 1) return word_t'((128 + MSG_BYTES) * 8);
    return '0;
  endfunction

  function automatic word_t rfc_tag_word(input logic full, input int i);
    if (full) return RFC_TAG512[511 - 32 * i -: 32];
    if (i < TAG384_DWORDS) return RFC_TAG384[383 - 32 * i -: 32];
    return '0;
  endfunction

  task automatic load_vector(input word_t first_key_word);
    for (int i = 0; i < KEY_DWORDS; i++) begin
      write_reg(KEY_BASE + addr_t'(4 * i), (i == 0) ? first_key_word : '0);
    end
    for (int i = 0; i < BLOCK_DWORDS; i++) begin
      write_reg(BLOCK_BASE + addr_t'(4 * i), padded_msg_word(i));
    end
  endtask

  task automatic compare_region(input string name, input addr_t base, input int count,
                                input logic full, input logic zero);
    for (int i = 0; i < count; i++) begin
      expect_reg($sformatf("%s[%0d]", name, i), base + addr_t'(4 * i),
                 zero ? '0 : rfc_tag_word(full, i));
    end
  endtask

  initial begin
    void'($urandom(32'hf09884fa));
    clk       = 1'b0;
    reset_n   = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    test_base = 0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;

    expect_reg("STATUS", STATUS_ADDR, 32'h1);
    check_word("error_intr", '0, word_t'(error_intr));
    check_word("notif_intr", '0, word_t'(notif_intr));
    check_word("busy", '0, word_t'(busy));
    end_test("reset state");

    load_vector(KEY_JEFE);
    write_reg(CTRL_ADDR, 32'h5);
    wait_for_flag("notif_intr");
    expect_reg("STATUS", STATUS_ADDR, 32'h3);
    compare_region("TAG", TAG_BASE, TAG_DWORDS, 1'b1, 1'b0);
    write_reg(INTR_ADDR, 32'h2);
    check_word("notif_intr", '0, word_t'(notif_intr));
    end_test("hmac-sha-512 rfc 4231 case 2");

    // key and block still hold the vector
    write_reg(CTRL_ADDR, 32'h1);
    wait_for_flag("notif_intr");
    compare_region("TAG", TAG_BASE, TAG_DWORDS, 1'b0, 1'b0);
    write_reg(INTR_ADDR, 32'h2);
    end_test("hmac-sha-384 rfc 4231 case 2");

    // zeroize first so the old tag is gone and the key is zero
    write_reg(CTRL_ADDR, 32'h8);
    write_reg(CTRL_ADDR, 32'h5);
    wait_for_flag("error_intr");
    expect_reg("STATUS", STATUS_ADDR, 32'h1);
    check_word("notif_intr", '0, word_t'(notif_intr));
    write_reg(INTR_ADDR, 32'h1);
    check_word("error_intr", '0, word_t'(error_intr));
    end_test("zero key rejected");

    load_vector(KEY_JEFE);
    write_reg(CTRL_ADDR, 32'h5);
    wait_for_flag("notif_intr");
    write_reg(INTR_ADDR, 32'h2);
    write_reg(CTRL_ADDR, 32'h8);
    compare_region("TAG", TAG_BASE, TAG_DWORDS, 1'b1, 1'b1);
    compare_region("KEY", KEY_BASE, KEY_DWORDS, 1'b1, 1'b1);
    compare_region("BLOCK", BLOCK_BASE, BLOCK_DWORDS, 1'b1, 1'b1);
    expect_reg("STATUS", STATUS_ADDR, 32'h1);
    end_test("zeroize after tag");

    load_vector(KEY_JEFE);
    write_reg(CTRL_ADDR, 32'h5);
    wait_for_flag("busy");
    write_reg(CTRL_ADDR, 32'h1);
    write_reg(KEY_BASE, 32'h0bad_f00d);
    check_word("busy", 32'h1, word_t'(busy));
    wait_for_flag("notif_intr");
    compare_region("TAG", TAG_BASE, TAG_DWORDS, 1'b1, 1'b0);
    expect_reg("KEY[0]", KEY_BASE, KEY_JEFE);
    write_reg(INTR_ADDR, 32'h2);
    end_test("writes ignored while busy");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
